// File: Makefile
# Verilator build for the sequential Booth multiplier

VERILATOR ?= verilator
TOP       ?= mdr_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass only when the pass message shows up as a line of its own
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | awk -v msg="$(PASS_MSG)" \
		'{ print } $$0 == msg { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

// File: booth/booth_datapath.sv
`timescale 1ns/1ps

`include "mdr_config.svh"

module booth_datapath (
	input  logic                clk,
	input  logic                rst,
	input  mdr_pkg::ctrl_t      i_ctrl,
	input  mdr_pkg::operands_t  i_operands,
	output mdr_pkg::product_t   o_product,
	output logic                o_last
);

	localparam int W  = `MDR_WIDTH;
	localparam int CW = `MDR_CNT_WIDTH;

	localparam logic [CW-1:0] STEPS    = CW'(W);
	localparam logic [CW-1:0] LAST_CNT = CW'(1);

	// Upper half, lower half, appended Booth bit
	logic signed [2*W:0]   r_acc;
	logic [CW-1:0]         r_cnt;
	logic signed [W-1:0]   upper;
	logic signed [W-1:0]   upper_sum;

	assign upper = r_acc[2*W:W+1];

	//////////////////////////////
	// Booth recoding
	//////////////////////////////

	always_comb begin
		case (r_acc[1:0])
			2'b01:   upper_sum = upper + i_operands.x; // End of a run of ones
			2'b10:   upper_sum = upper - i_operands.x; // Start of a run
			default: upper_sum = upper;
		endcase
	end

	//////////////////////////////
	// Accumulator and counter
	//////////////////////////////

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			r_acc <= '0;
		end else if (i_ctrl.clean) begin
			r_acc <= '0;
		end else if (i_ctrl.init) begin
			r_acc <= {{W{1'b0}}, i_operands.y, 1'b0};
		end else if (i_ctrl.enable) begin
			// Arithmetic shift right of {upper_sum, lower, appended bit}
			r_acc <= {upper_sum[W-1], upper_sum, r_acc[W:1]};
		end
	end

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			r_cnt <= '0;
		end else if (i_ctrl.clean) begin
			r_cnt <= '0;
		end else if (i_ctrl.init) begin
			r_cnt <= STEPS;
		end else if (i_ctrl.enable) begin
			r_cnt <= r_cnt - 1'b1;
		end
	end

	assign o_last    = i_ctrl.enable && (r_cnt == LAST_CNT);
	assign o_product = r_acc[2*W:1]; // Drop the appended bit

endmodule

// File: common/mdr_config.svh
`ifndef MDR_CONFIG_SVH
`define MDR_CONFIG_SVH

// Operand word width, 4 to 16 bits
`define MDR_WIDTH 8

// Product is twice the operand width
`define MDR_PROD_WIDTH (2 * `MDR_WIDTH)

// Step counter must hold MDR_WIDTH itself
`define MDR_CNT_WIDTH ($clog2(`MDR_WIDTH + 1))

`endif

// File: common/mdr_pkg.sv
`include "mdr_config.svh"

package mdr_pkg;

	//////////////////////////////
	// Control FSM
	//////////////////////////////

	typedef enum logic [2:0] {
		IDLE,
		CLEAN,
		WAIT_X,
		WAIT_Y,
		VERIFICATION,
		INIT,
		CALCULATION,
		READY
	} state_t;

	// One bit per datapath action, decoded from the state
	typedef struct packed {
		logic clean;
		logic load_x;
		logic load_y;
		logic veri;
		logic init;
		logic error;  // Only in VERIFICATION with a bad operand
		logic enable; // One Booth step
		logic ready;
	} ctrl_t;

	//////////////////////////////
	// Datapath payloads
	//////////////////////////////

	typedef struct packed {
		logic signed [`MDR_WIDTH-1:0] x; // Multiplicand
		logic signed [`MDR_WIDTH-1:0] y; // Multiplier
	} operands_t;

	typedef logic signed [`MDR_PROD_WIDTH-1:0] product_t;

endpackage

// File: control/mdr_control.sv
`timescale 1ns/1ps

module mdr_control (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_start, // Active low
	input  logic            i_load,  // Active low
	input  logic            i_error,
	input  logic            i_last,
	output mdr_pkg::ctrl_t  o_ctrl,
	output logic            o_ready,
	output logic            o_error
);

	mdr_pkg::state_t r_state;

	//////////////////////////////
	// State register
	//////////////////////////////

	always_ff @(posedge clk, negedge rst) begin : state_machine
		if (!rst) begin
			r_state <= mdr_pkg::IDLE;
		end else begin
			case (r_state)
				mdr_pkg::IDLE: begin
					if (!i_start)
						r_state <= mdr_pkg::CLEAN;
				end

				mdr_pkg::CLEAN:
					r_state <= mdr_pkg::WAIT_X;

				mdr_pkg::WAIT_X: begin
					if (!i_load)
						r_state <= mdr_pkg::WAIT_Y;
				end

				mdr_pkg::WAIT_Y: begin
					if (!i_load)
						r_state <= mdr_pkg::VERIFICATION;
				end

				// Bad operand aborts the run
				mdr_pkg::VERIFICATION: begin
					if (i_error)
						r_state <= mdr_pkg::IDLE;
					else
						r_state <= mdr_pkg::INIT;
				end

				mdr_pkg::INIT:
					r_state <= mdr_pkg::CALCULATION;

				mdr_pkg::CALCULATION: begin
					if (i_last)
						r_state <= mdr_pkg::READY;
				end

				mdr_pkg::READY:
					r_state <= mdr_pkg::IDLE;

				default:
					r_state <= mdr_pkg::IDLE;
			endcase
		end
	end : state_machine

	//////////////////////////////
	// Output decode
	//////////////////////////////

	always_comb begin : outputs
		o_ctrl = '0;
		case (r_state)
			mdr_pkg::CLEAN:
				o_ctrl.clean = 1'b1;
			mdr_pkg::WAIT_X:
				o_ctrl.load_x = 1'b1;   // X follows i_data while waiting
			mdr_pkg::WAIT_Y:
				o_ctrl.load_y = 1'b1;
			mdr_pkg::VERIFICATION: begin
				o_ctrl.veri  = 1'b1;
				o_ctrl.error = i_error; // Mealy exception
			end
			mdr_pkg::INIT:
				o_ctrl.init = 1'b1;
			mdr_pkg::CALCULATION:
				o_ctrl.enable = 1'b1;
			mdr_pkg::READY:
				o_ctrl.ready = 1'b1;
			default:
				o_ctrl = '0;
		endcase
	end : outputs

	assign o_ready = o_ctrl.ready;
	assign o_error = o_ctrl.error;

endmodule

// File: hw/mdr_operand_regs.sv
`timescale 1ns/1ps

`include "mdr_config.svh"

module mdr_operand_regs (
	input  logic                          clk,
	input  logic                          rst,
	input  mdr_pkg::ctrl_t                i_ctrl,
	input  logic signed [`MDR_WIDTH-1:0]  i_data,
	output mdr_pkg::operands_t            o_operands,
	output logic                          o_error
);

	localparam int W = `MDR_WIDTH;

	// Booth overflows on this one value
	localparam logic signed [W-1:0] MOST_NEG = {1'b1, {(W-1){1'b0}}};

	mdr_pkg::operands_t r_ops;

	//////////////////////////////
	// Operand capture
	//////////////////////////////

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			r_ops <= '0;
		end else if (i_ctrl.clean) begin
			r_ops <= '0;
		end else begin
			if (i_ctrl.load_x)
				r_ops.x <= i_data; // Last value before the strobe stays
			if (i_ctrl.load_y)
				r_ops.y <= i_data;
		end
	end

	//////////////////////////////
	// Verification
	//////////////////////////////

	always_comb begin
		o_error = 1'b0;
		if (r_ops.x == MOST_NEG)
			o_error = 1'b1;
		if (r_ops.y == MOST_NEG)
			o_error = 1'b1;
	end

	assign o_operands = r_ops;

endmodule

// File: hw/mdr_top.sv
`timescale 1ns/1ps

`include "mdr_config.svh"

module mdr_top (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          i_start, // Active low
	input  logic                          i_load,  // Active low
	input  logic signed [`MDR_WIDTH-1:0]  i_data,
	output mdr_pkg::product_t             o_product,
	output logic                          o_ready,
	output logic                          o_error
);

	mdr_pkg::ctrl_t      ctrl;
	mdr_pkg::operands_t  operands;
	logic                op_error; // Bad operand seen by the FSM
	logic                last;

	mdr_control u_control (
		.clk      (clk),
		.rst      (rst),
		.i_start  (i_start),
		.i_load   (i_load),
		.i_error  (op_error),
		.i_last   (last),
		.o_ctrl   (ctrl),
		.o_ready  (o_ready),
		.o_error  (o_error)
	);

	mdr_operand_regs u_operand_regs (
		.clk         (clk),
		.rst         (rst),
		.i_ctrl      (ctrl),
		.i_data      (i_data),
		.o_operands  (operands),
		.o_error     (op_error)
	);

	booth_datapath u_booth (
		.clk         (clk),
		.rst         (rst),
		.i_ctrl      (ctrl),
		.i_operands  (operands),
		.o_product   (o_product),
		.o_last      (last)
	);

endmodule

// File: sources.f
+incdir+common
common/mdr_pkg.sv
control/mdr_control.sv
hw/mdr_operand_regs.sv
booth/booth_datapath.sv
hw/mdr_top.sv
tb/mdr_checker.sv
tb/mdr_tb.sv

// File: tb/mdr_checker.sv
`timescale 1ns/1ps

`include "mdr_config.svh"

module mdr_checker (
	input  logic            clk,
	input  logic            rst,
	input  mdr_pkg::ctrl_t  i_ctrl,
	input  logic            i_ready,
	input  logic            i_error
);

	localparam int W  = `MDR_WIDTH;
	localparam int RW = `MDR_CNT_WIDTH + 1;

	localparam logic [RW-1:0] RUN_LEN = RW'(W);

	logic [RW-1:0] r_run; // Enable cycles since the last init

	always_ff @(posedge clk, negedge rst) begin
		if (!rst)
			r_run <= '0;
		else if (i_ctrl.init)
			r_run <= '0;
		else if (i_ctrl.enable)
			r_run <= r_run + 1'b1;
	end

	//////////////////////////////
	// Control FSM properties
	//////////////////////////////

	a_ready_pulse: assert property (@(posedge clk) disable iff (!rst)
		i_ready |=> !i_ready)
		else $error("ready stayed high for two cycles");

	a_error_in_veri: assert property (@(posedge clk) disable iff (!rst)
		i_error |-> i_ctrl.veri)
		else $error("error raised outside verification");

	// Calculation starts right after init
	a_init_then_enable: assert property (@(posedge clk) disable iff (!rst)
		i_ctrl.init |=> i_ctrl.enable)
		else $error("init not followed by enable");

	a_enable_bound: assert property (@(posedge clk) disable iff (!rst)
		i_ctrl.enable |-> (r_run < RUN_LEN))
		else $error("more enable cycles than operand bits");

	a_enable_length: assert property (@(posedge clk) disable iff (!rst)
		($past(i_ctrl.enable) && !i_ctrl.enable) |-> (r_run == RUN_LEN))
		else $error("enable run shorter than operand width");

	a_one_control: assert property (@(posedge clk) disable iff (!rst)
		$onehot0({i_ctrl.clean, i_ctrl.load_x, i_ctrl.load_y, i_ctrl.veri,
			i_ctrl.init, i_ctrl.enable, i_ctrl.ready}))
		else $error("several control fields high at once");

endmodule

bind mdr_control mdr_checker u_checker (
	.clk      (clk),
	.rst      (rst),
	.i_ctrl   (o_ctrl),
	.i_ready  (o_ready),
	.i_error  (o_error)
);

// File: tb/mdr_input.txt
# Columns: X Y error product, all hex; X and Y are 8-bit signed, product 16-bit signed
# error is 1 when X or Y is the most negative value; product is then unused
03 05 0 000F
00 00 0 0000
07 00 0 0000
00 F9 0 0000
7F 7F 0 3F01
81 81 0 3F01
7F 81 0 C0FF
81 7F 0 C0FF
FF FF 0 0001
FF 01 0 FFFF
80 05 1 0000
0C 0A 0 0078
05 80 1 0000
F6 0C 0 FF88
80 80 1 0000
64 64 0 2710
9C 64 0 D8F0
9C 9C 0 2710
55 AA 0 E372
2A 13 0 031E
01 80 1 0000
40 02 0 0080
40 40 0 1000
C0 40 0 F000
C0 C0 0 1000
12 EE 0 FEBC
7F 01 0 007F
01 81 0 FF81
E7 19 0 FD8F
33 03 0 0099

// File: tb/mdr_tb.sv
`timescale 1ns/1ps

`include "mdr_config.svh"

module mdr_tb;

	localparam int W          = `MDR_WIDTH;
	localparam int CLK_PERIOD = 8;
	localparam int RST_CYCLES = 16;
	localparam int DRIVE_DLY  = 1;
	localparam int READY_LAT  = W + 2; // VERIFICATION cycle to READY cycle

	logic                clk;
	logic                rst;
	logic                i_start;
	logic                i_load;
	logic signed [W-1:0] i_data;
	mdr_pkg::product_t   o_product;
	logic                o_ready;
	logic                o_error;

	logic [W-1:0]        vec_x[$];
	logic [W-1:0]        vec_y[$];
	logic                vec_err[$];
	mdr_pkg::product_t   vec_prod[$];
	int                  n_vec;
	logic                vectors_loaded;
	logic [31:0]         rand_state;
	mdr_pkg::product_t   last_product; // Value o_product must hold

	mdr_top dut0 (
		.clk        (clk),
		.rst        (rst),
		.i_start    (i_start),
		.i_load     (i_load),
		.i_data     (i_data),
		.o_product  (o_product),
		.o_ready    (o_ready),
		.o_error    (o_error)
	);

	initial begin : clock_gen
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] lcg_next();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	function automatic int random_gap();
		logic [31:0] r;
		r = lcg_next();
		return int'(r[17:16]); // 0 to 3 cycles
	endfunction

	task automatic drive_junk();
		logic [31:0] r;
		r = lcg_next();
		i_data = r[W-1:0];
	endtask

	task automatic wait_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic compare_product(input string name, input mdr_pkg::product_t exp,
		input mdr_pkg::product_t act);
		if (act !== exp)
			stop_with_failure($sformatf("Fail %s: expected %0d (0x%h), actual %0d (0x%h)",
				name, exp, exp, act, act));
	endtask

	task automatic compare_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_with_failure($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic compare_count(input string name, input int exp, input int act);
		if (act != exp)
			stop_with_failure($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic read_vectors();
		int fd;
		int n;
		string line;
		logic [31:0] x;
		logic [31:0] y;
		logic [31:0] e;
		logic [31:0] p;
		fd = $fopen("tb/mdr_input.txt", "r");
		if (fd == 0)
			stop_with_failure("Could not open the vector file tb/mdr_input.txt");
		while ($fgets(line, fd) != 0) begin
			if (line.len() == 0 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h", x, y, e, p);
			if (n != 4)
				continue;
			vec_x.push_back(x[W-1:0]);
			vec_y.push_back(y[W-1:0]);
			vec_err.push_back(e[0]);
			vec_prod.push_back(p[2*W-1:0]);
		end
		$fclose(fd);
		n_vec = vec_x.size();
		if (n_vec == 0)
			stop_with_failure("The vector file holds no vectors");
		vectors_loaded = 1'b1;
	endtask

	//////////////////////////////
	// Sequences
	//////////////////////////////

	task automatic check_reset_state();
		int i;
		compare_flag("reset ready", 1'b0, o_ready);
		compare_flag("reset error", 1'b0, o_error);
		compare_product("reset product", '0, o_product);
		for (i = 0; i < 4; i++) begin
			drive_junk();
			i_load = (i == 1) ? 1'b0 : 1'b1; // Ignored in IDLE
			wait_cycle();
			compare_flag("idle ready", 1'b0, o_ready);
			compare_flag("idle error", 1'b0, o_error);
			compare_product("idle product", '0, o_product);
		end
		i_load = 1'b1;
	endtask

	// Entered in a WAIT state with load high
	task automatic load_operand(input logic [W-1:0] value);
		int gap;
		gap = random_gap();
		repeat (gap + 1) begin
			drive_junk(); // Register follows this until the strobe
			wait_cycle();
		end
		i_data = value;
		i_load = 1'b0;
		wait_cycle();
		i_load = 1'b1;
		drive_junk();
	endtask

	task automatic run_vector(input int idx);
		string name;
		int cycles;
		int gap;
		name = $sformatf("vector %0d", idx);
		i_start = 1'b0;
		wait_cycle();
		i_start = 1'b1;
		compare_product({name, " held"}, last_product, o_product); // CLEAN not yet applied
		wait_cycle();
		compare_product({name, " clean"}, '0, o_product);
		load_operand(vec_x[idx]);
		load_operand(vec_y[idx]);

		// Now in VERIFICATION
		compare_flag({name, " error"}, vec_err[idx], o_error);
		compare_flag({name, " ready"}, 1'b0, o_ready);
		if (vec_err[idx]) begin
			repeat (W + 4) begin
				wait_cycle();
				compare_flag({name, " no ready"}, 1'b0, o_ready);
				compare_flag({name, " error pulse"}, 1'b0, o_error);
			end
			last_product = '0;
		end else begin
			cycles = 0;
			while (o_ready !== 1'b1 && cycles < READY_LAT + 2) begin
				wait_cycle();
				cycles++;
			end
			if (o_ready !== 1'b1)
				stop_with_failure($sformatf("%s: no ready pulse within %0d cycles",
					name, cycles));
			compare_count({name, " latency"}, READY_LAT, cycles);
			compare_product({name, " product"}, vec_prod[idx], o_product);
			last_product = vec_prod[idx];
		end

		gap = random_gap();
		repeat (gap + 1) begin
			wait_cycle();
			drive_junk();
			compare_flag({name, " ready pulse"}, 1'b0, o_ready);
			compare_product({name, " hold"}, last_product, o_product);
		end
	endtask

	//////////////////////////////
	// Main and watchdog
	//////////////////////////////

	initial begin : main
		int i;
		rst = 1'b0;
		i_start = 1'b1;
		i_load = 1'b1;
		i_data = '0;
		rand_state = 32'h74e6b612;
		vectors_loaded = 1'b0;
		last_product = '0;
		read_vectors();
		repeat (RST_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b1;
		check_reset_state();
		for (i = 0; i < n_vec; i++)
			run_vector(i);
		$display("Done: no errors");
		$finish;
	end

	initial begin : watchdog
		wait (vectors_loaded);
		#((RST_CYCLES + 8 + n_vec * (W + 20)) * CLK_PERIOD);
		stop_with_failure("Watchdog expired before all vectors finished");
	end

endmodule
